/* source/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

    // {register number, select}
    typedef enum logic [7:0] {
        cp0_n_index    = 8'h00,
        cp0_n_random   = 8'h08,
        cp0_n_entrylo0 = 8'h10,
        cp0_n_entrylo1 = 8'h18,
        cp0_n_context  = 8'h20,
        cp0_n_pagemask = 8'h28,
        cp0_n_wired    = 8'h30,
        cp0_n_badvaddr = 8'h40,
        cp0_n_count    = 8'h48,
        cp0_n_entryhi  = 8'h50,
        cp0_n_compare  = 8'h58,
        cp0_n_status   = 8'h60,
        cp0_n_cause    = 8'h68,
        cp0_n_epc      = 8'h70,
        cp0_n_prid     = 8'h78,
        cp0_n_ebase    = 8'h79,
        cp0_n_config0  = 8'h80,
        cp0_n_config1  = 8'h81,
        cp0_n_taglo0   = 8'he0,
        cp0_n_taghi0   = 8'he8
    } cp0_number_t;

    parameter logic [31:0] status_init  = 32'h0040_0000;
    parameter logic [31:0] ebase_init   = 32'h8000_0000;
    parameter logic [31:0] prid_value   = 32'h0001_8003;
    parameter logic [31:0] random_init  = 32'd31;
    // M set, MT = 1, K0 = 3 (cacheable)
    parameter logic [31:0] config0_init = 32'h8000_0083;
    parameter logic [31:0] config1_init = {1'b0, 6'd31, 3'd0, 3'd5, 3'd1, 3'd0, 3'd5, 3'd1, 7'd0};

    parameter logic [31:0] status_wmask   = 32'h1040_ff13;
    parameter logic [31:0] cause_wmask    = 32'h0080_0300;
    parameter logic [31:0] entryhi_wmask  = 32'hffff_e0ff;
    parameter logic [31:0] ebase_wmask    = 32'h3fff_f000;
    parameter logic [31:0] config0_wmask  = 32'h0000_0007;
    parameter logic [31:0] entrylo_wmask  = 32'h03ff_ffff;
    parameter logic [31:0] context_wmask  = 32'hff80_0000;
    parameter logic [31:0] pagemask_wmask = 32'h1fff_e000;

endpackage

`default_nettype wire

/* source/exc_pkg.sv */
`default_nettype none

package exc_pkg;

    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_mod  = 5'd1,
        exc_tlbl = 5'd2,
        exc_tlbs = 5'd3,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_sys  = 5'd8,
        exc_bp   = 5'd9,
        exc_ri   = 5'd10,
        exc_ov   = 5'd12,
        // not a MIPS code, marks the return from a handler
        exc_eret = 5'd31
    } exc_code_t;

    // base used while Status.BEV is set
    parameter logic [31:0] boot_vector_base = 32'hbfc0_0200;
    parameter logic [31:0] general_offset   = 32'h0000_0180;
    parameter logic [31:0] interrupt_offset = 32'h0000_0200;

endpackage

`default_nettype wire

/* source/cp0_ifaces.sv */
`default_nettype none

interface cp0_access_if;
    logic                   we;
    cp0_pkg::cp0_number_t   reg_num;
    logic [31:0]            wdata;
    logic [31:0]            rdata;

    modport ctrl (output we, output reg_num, output wdata, input rdata);
    modport regs (input we, input reg_num, input wdata, output rdata);
    // timer only watches for Count and Compare writes
    modport timer (input we, input reg_num, input wdata);
endinterface

interface cp0_exc_if;
    logic                   valid;
    exc_pkg::exc_code_t     code;
    logic                   bd;
    logic [31:0]            epc;
    logic [31:0]            badvaddr;

    modport regs (
        input valid,
        input code,
        input bd,
        input epc,
        input badvaddr
    );
endinterface

`default_nettype wire

/* source/cp0_access_ctrl.sv */
`default_nettype none

module cp0_access_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_i,
    input  logic                    write_i,
    input  cp0_pkg::cp0_number_t    reg_num_i,
    input  logic [31:0]             wdata_i,
    output logic                    ack_o,
    output logic [31:0]             rdata_o,
    cp0_access_if.ctrl              acc
);

    typedef enum logic {
        st_idle,
        st_acked
    } state_t;

    state_t      state_q;
    logic        start;

    // a new access begins only from idle, so one pulse per handshake
    assign start = (state_q == st_idle) && req_i;

    assign acc.we      = start && write_i;
    assign acc.reg_num = reg_num_i;
    assign acc.wdata   = wdata_i;

    assign ack_o = (state_q == st_acked);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (req_i) begin
                        state_q <= st_acked;
                    end
                end
                st_acked: begin
                    if (!req_i) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // value before the write of the same access
    always_ff @(posedge clk) begin
        if (start) begin
            rdata_o <= acc.rdata;
        end
    end

endmodule

`default_nettype wire

/* source/cp0_timer.sv */
`default_nettype none

module cp0_timer (
    input  logic        clk,
    input  logic        reset,
    cp0_access_if.timer acc,
    output logic [31:0] count_o,
    output logic [31:0] compare_o,
    output logic        timer_int_o
);

    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic        tick_q;
    logic        timer_int_q;
    logic        count_wr;
    logic        compare_wr;

    assign count_wr   = acc.we && (acc.reg_num == cp0_pkg::cp0_n_count);
    assign compare_wr = acc.we && (acc.reg_num == cp0_pkg::cp0_n_compare);

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q     <= 32'd0;
            compare_q   <= 32'd0;
            tick_q      <= 1'b0;
            timer_int_q <= 1'b0;
        end else begin
            // count runs at half the core clock
            tick_q <= ~tick_q;
            if (count_wr) begin
                count_q <= acc.wdata;
            end else if (tick_q) begin
                count_q <= count_q + 32'd1;
            end

            if (compare_wr) begin
                compare_q   <= acc.wdata;
                timer_int_q <= 1'b0;
            end else if (compare_q != 32'd0 && count_q == compare_q) begin
                timer_int_q <= 1'b1;
            end
        end
    end

    assign count_o     = count_q;
    assign compare_o   = compare_q;
    assign timer_int_o = timer_int_q;

endmodule

`default_nettype wire

/* source/cp0_regs.sv */
`default_nettype none

module cp0_regs #(
    parameter int tlb_idx_bits = 5
) (
    input  logic        clk,
    input  logic        reset,
    cp0_access_if.regs  acc,
    cp0_exc_if.regs     exc,
    input  logic [31:0] count_i,
    input  logic [31:0] compare_i,
    input  logic        timer_int_i,
    input  logic [4:0]  hw_int_i,
    output logic [31:0] epc_o,
    output logic [31:0] exc_handler_o,
    output logic [31:0] int_handler_o,
    output logic [31:0] tlb_refill_handler_o,
    output logic        interrupt_pending_o,
    output logic        kseg0_cached_o
);

    logic [tlb_idx_bits-1:0] index_q, random_q, wired_q;
    logic [31:0] entrylo0_q, entrylo1_q, context_q, pagemask_q, badvaddr_q;
    logic [31:0] entryhi_q, status_q, cause_q, epc_q, ebase_q;
    logic [31:0] config0_q, taglo0_q, taghi0_q;
    logic [4:0]  hw_int_q;
    logic [7:0]  cause_ip;
    logic [31:0] cause_rd;
    logic [31:0] vec_base;

    function automatic logic [31:0] merge(input logic [31:0] old_v, input logic [31:0] new_v,
                                          input logic [31:0] mask);
        merge = (old_v & ~mask) | (new_v & mask);
    endfunction

    assign cause_ip = {timer_int_i, hw_int_q, cause_q[9:8]};
    assign cause_rd = {cause_q[31:16], cause_ip, cause_q[7:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            index_q    <= '0;
            random_q   <= cp0_pkg::random_init[tlb_idx_bits-1:0];
            wired_q    <= '0;
            entrylo0_q <= 32'd0;
            entrylo1_q <= 32'd0;
            context_q  <= 32'd0;
            pagemask_q <= 32'd0;
            badvaddr_q <= 32'd0;
            entryhi_q  <= 32'd0;
            status_q   <= cp0_pkg::status_init;
            cause_q    <= 32'd0;
            epc_q      <= 32'd0;
            ebase_q    <= cp0_pkg::ebase_init;
            config0_q  <= cp0_pkg::config0_init;
            taglo0_q   <= 32'd0;
            taghi0_q   <= 32'd0;
            hw_int_q   <= 5'd0;
        end else begin
            hw_int_q <= hw_int_i;
            // a write in the same cycle drops the exception
            if (acc.we) begin
                case (acc.reg_num)
                    cp0_pkg::cp0_n_index:    index_q <= acc.wdata[tlb_idx_bits-1:0];
                    cp0_pkg::cp0_n_entrylo0:
                        entrylo0_q <= merge(entrylo0_q, acc.wdata, cp0_pkg::entrylo_wmask);
                    cp0_pkg::cp0_n_entrylo1:
                        entrylo1_q <= merge(entrylo1_q, acc.wdata, cp0_pkg::entrylo_wmask);
                    cp0_pkg::cp0_n_context:
                        context_q <= merge(context_q, acc.wdata, cp0_pkg::context_wmask);
                    cp0_pkg::cp0_n_pagemask:
                        pagemask_q <= merge(pagemask_q, acc.wdata, cp0_pkg::pagemask_wmask);
                    cp0_pkg::cp0_n_wired: begin
                        wired_q  <= acc.wdata[tlb_idx_bits-1:0];
                        random_q <= {tlb_idx_bits{1'b1}};
                    end
                    cp0_pkg::cp0_n_entryhi:
                        entryhi_q <= merge(entryhi_q, acc.wdata, cp0_pkg::entryhi_wmask);
                    cp0_pkg::cp0_n_status:
                        status_q <= merge(status_q, acc.wdata, cp0_pkg::status_wmask);
                    cp0_pkg::cp0_n_cause:
                        cause_q <= merge(cause_q, acc.wdata, cp0_pkg::cause_wmask);
                    cp0_pkg::cp0_n_epc:      epc_q <= acc.wdata;
                    cp0_pkg::cp0_n_ebase:
                        ebase_q <= merge(ebase_q, acc.wdata, cp0_pkg::ebase_wmask);
                    cp0_pkg::cp0_n_config0:
                        config0_q <= merge(config0_q, acc.wdata, cp0_pkg::config0_wmask);
                    cp0_pkg::cp0_n_taglo0:   taglo0_q <= acc.wdata;
                    cp0_pkg::cp0_n_taghi0:   taghi0_q <= acc.wdata;
                    default: ;
                endcase
            end else if (exc.valid) begin
                if (exc.code == exc_pkg::exc_eret) begin
                    status_q[1] <= 1'b0;
                end else begin
                    case (exc.code)
                        exc_pkg::exc_adel, exc_pkg::exc_ades: badvaddr_q <= exc.badvaddr;
                        exc_pkg::exc_tlbl, exc_pkg::exc_tlbs, exc_pkg::exc_mod: begin
                            badvaddr_q       <= exc.badvaddr;
                            context_q[22:4]  <= exc.badvaddr[31:13];
                            entryhi_q[31:13] <= exc.badvaddr[31:13];
                        end
                        default: ;
                    endcase
                    cause_q[6:2] <= exc.code;
                    status_q[1]  <= 1'b1;
                    // nested exception keeps the first EPC and BD
                    if (!status_q[1]) begin
                        cause_q[31] <= exc.bd;
                        epc_q       <= exc.epc;
                    end
                end
            end
        end
    end

    always_comb begin
        case (acc.reg_num)
            cp0_pkg::cp0_n_index:    acc.rdata = 32'(index_q);
            cp0_pkg::cp0_n_random:   acc.rdata = 32'(random_q);
            cp0_pkg::cp0_n_entrylo0: acc.rdata = entrylo0_q;
            cp0_pkg::cp0_n_entrylo1: acc.rdata = entrylo1_q;
            cp0_pkg::cp0_n_context:  acc.rdata = context_q;
            cp0_pkg::cp0_n_pagemask: acc.rdata = pagemask_q;
            cp0_pkg::cp0_n_wired:    acc.rdata = 32'(wired_q);
            cp0_pkg::cp0_n_badvaddr: acc.rdata = badvaddr_q;
            cp0_pkg::cp0_n_count:    acc.rdata = count_i;
            cp0_pkg::cp0_n_entryhi:  acc.rdata = entryhi_q;
            cp0_pkg::cp0_n_compare:  acc.rdata = compare_i;
            cp0_pkg::cp0_n_status:   acc.rdata = status_q;
            cp0_pkg::cp0_n_cause:    acc.rdata = cause_rd;
            cp0_pkg::cp0_n_epc:      acc.rdata = epc_q;
            cp0_pkg::cp0_n_prid:     acc.rdata = cp0_pkg::prid_value;
            cp0_pkg::cp0_n_ebase:    acc.rdata = ebase_q;
            cp0_pkg::cp0_n_config0:  acc.rdata = config0_q;
            cp0_pkg::cp0_n_config1:  acc.rdata = cp0_pkg::config1_init;
            cp0_pkg::cp0_n_taglo0:   acc.rdata = taglo0_q;
            cp0_pkg::cp0_n_taghi0:   acc.rdata = taghi0_q;
            default:                 acc.rdata = 32'd0;
        endcase
    end

    // IE set, EXL and ERL clear
    assign interrupt_pending_o = (|(status_q[15:8] & cause_ip)) && (status_q[2:0] == 3'b001);

    assign vec_base = status_q[22] ? exc_pkg::boot_vector_base : {ebase_q[31:12], 12'd0};
    assign exc_handler_o = vec_base + exc_pkg::general_offset;
    assign int_handler_o = cause_q[23] ? vec_base + exc_pkg::interrupt_offset
                                       : vec_base + exc_pkg::general_offset;
    assign tlb_refill_handler_o = status_q[1] ? vec_base + exc_pkg::general_offset : vec_base;

    assign epc_o          = epc_q;
    assign kseg0_cached_o = (config0_q[2:0] == 3'd3);

endmodule

`default_nettype wire

/* source/cp0_unit.sv */
`default_nettype none

module cp0_unit #(
    parameter int tlb_idx_bits = 5
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_i,
    input  logic                    write_i,
    input  cp0_pkg::cp0_number_t    reg_num_i,
    input  logic [31:0]             wdata_i,
    output logic                    ack_o,
    output logic [31:0]             rdata_o,
    input  logic                    exc_valid_i,
    input  exc_pkg::exc_code_t      exc_code_i,
    input  logic                    exc_bd_i,
    input  logic [31:0]             exc_epc_i,
    input  logic [31:0]             exc_badvaddr_i,
    input  logic [4:0]              hw_int_i,
    output logic [31:0]             epc_o,
    output logic [31:0]             exc_handler_o,
    output logic [31:0]             int_handler_o,
    output logic [31:0]             tlb_refill_handler_o,
    output logic                    interrupt_pending_o,
    output logic                    kseg0_cached_o
);

    logic [31:0] count;
    logic [31:0] compare;
    logic        timer_int;

    cp0_access_if acc_if ();
    cp0_exc_if    exc_if ();

    // pipeline exception report
    assign exc_if.valid    = exc_valid_i;
    assign exc_if.code     = exc_code_i;
    assign exc_if.bd       = exc_bd_i;
    assign exc_if.epc      = exc_epc_i;
    assign exc_if.badvaddr = exc_badvaddr_i;

    cp0_access_ctrl access_ctrl_i (
        .clk       (clk),
        .reset     (reset),
        .req_i     (req_i),
        .write_i   (write_i),
        .reg_num_i (reg_num_i),
        .wdata_i   (wdata_i),
        .ack_o     (ack_o),
        .rdata_o   (rdata_o),
        .acc       (acc_if.ctrl)
    );

    cp0_timer timer_i (
        .clk         (clk),
        .reset       (reset),
        .acc         (acc_if.timer),
        .count_o     (count),
        .compare_o   (compare),
        .timer_int_o (timer_int)
    );

    cp0_regs #(
        .tlb_idx_bits (tlb_idx_bits)
    ) regs_i (
        .clk                  (clk),
        .reset                (reset),
        .acc                  (acc_if.regs),
        .exc                  (exc_if.regs),
        .count_i              (count),
        .compare_i            (compare),
        .timer_int_i          (timer_int),
        .hw_int_i             (hw_int_i),
        .epc_o                (epc_o),
        .exc_handler_o        (exc_handler_o),
        .int_handler_o        (int_handler_o),
        .tlb_refill_handler_o (tlb_refill_handler_o),
        .interrupt_pending_o  (interrupt_pending_o),
        .kseg0_cached_o       (kseg0_cached_o)
    );

endmodule

`default_nettype wire

/* tests/cp0_unit_chk.sv */
`default_nettype none

module cp0_unit_chk (
    input logic clk,
    input logic reset,
    input logic req_i,
    input logic ack_o,
    input logic we_i
);

    // one write pulse per handshake
    we_single_cycle: assert property (@(posedge clk) disable iff (reset) we_i |=> !we_i)
        else $error("write pulse lasted more than one cycle");

    ack_needs_req: assert property (
        @(posedge clk) disable iff (reset) $rose(ack_o) |-> $past(req_i)
    ) else $error("ack rose without a pending request");

    ack_low_after_reset: assert property (@(posedge clk) $past(reset) |-> !ack_o)
        else $error("ack high right after reset");

endmodule

bind cp0_access_ctrl cp0_unit_chk chk_i (
    .clk   (clk),
    .reset (reset),
    .req_i (req_i),
    .ack_o (ack_o),
    .we_i  (acc.we)
);

`default_nettype wire

/* tests/cp0_unit_tb.sv */
`default_nettype none

module cp0_unit_tb;

    // a bit over twice the run with every handshake at its ack limit
    localparam int max_cycles = 3000;
    localparam int ack_limit  = 20;

    logic                 clk;
    logic                 reset;
    logic                 req_i;
    logic                 write_i;
    cp0_pkg::cp0_number_t reg_num_i;
    logic [31:0]          wdata_i;
    logic                 ack_o;
    logic [31:0]          rdata_o;
    logic                 exc_valid_i;
    exc_pkg::exc_code_t   exc_code_i;
    logic                 exc_bd_i;
    logic [31:0]          exc_epc_i;
    logic [31:0]          exc_badvaddr_i;
    logic [4:0]           hw_int_i;
    logic [31:0]          epc_o;
    logic [31:0]          exc_handler_o;
    logic [31:0]          int_handler_o;
    logic [31:0]          tlb_refill_handler_o;
    logic                 interrupt_pending_o;
    logic                 kseg0_cached_o;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycles       = 0;
    int err_mark;

    cp0_unit #(.tlb_idx_bits(5)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    // full four-phase cycle, returns the value captured with ack
    task automatic handshake(input logic wr, input cp0_pkg::cp0_number_t num,
                             input logic [31:0] data, output logic [31:0] rd);
        int waited;
        waited = 0;
        @(posedge clk);
        req_i     <= 1'b1;
        write_i   <= wr;
        reg_num_i <= num;
        wdata_i   <= data;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack_o && waited <= ack_limit);
        if (!ack_o) begin
            $display("handshake timeout: no ack for register 0x%02h within %0d cycles",
                     num, ack_limit);
            errors++;
        end
        rd = rdata_o;
        @(posedge clk);
        req_i   <= 1'b0;
        write_i <= 1'b0;
        do @(negedge clk); while (ack_o);
    endtask

    task automatic cp0_write(input cp0_pkg::cp0_number_t num, input logic [31:0] data);
        logic [31:0] unused_rd;
        handshake(1'b1, num, data, unused_rd);
    endtask

    task automatic cp0_read(input cp0_pkg::cp0_number_t num, output logic [31:0] rd);
        handshake(1'b0, num, 32'd0, rd);
    endtask

    task automatic expect_reg(input cp0_pkg::cp0_number_t num, input string name,
                              input logic [31:0] expected);
        logic [31:0] rd;
        cp0_read(num, rd);
        check_word(name, expected, rd);
    endtask

    task automatic pulse_exception(input exc_pkg::exc_code_t code, input logic bd,
                                   input logic [31:0] epc, input logic [31:0] addr);
        @(posedge clk);
        exc_valid_i    <= 1'b1;
        exc_code_i     <= code;
        exc_bd_i       <= bd;
        exc_epc_i      <= epc;
        exc_badvaddr_i <= addr;
        @(posedge clk);
        exc_valid_i <= 1'b0;
        @(negedge clk);
    endtask

    // line is registered once, so look after the second edge
    task automatic drive_hw_lines(input logic [4:0] lines);
        @(posedge clk);
        hw_int_i <= lines;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", name, errors - errors_before);
        end
    endtask

    task automatic reset_state();
        @(negedge clk);
        check_bit("kseg0_cached_o", 1'b1, kseg0_cached_o);
        check_word("exc_handler_o", 32'hbfc0_0380, exc_handler_o);
        check_word("int_handler_o", 32'hbfc0_0380, int_handler_o);
        check_word("tlb_refill_handler_o", 32'hbfc0_0200, tlb_refill_handler_o);
        check_bit("interrupt_pending_o", 1'b0, interrupt_pending_o);
        expect_reg(cp0_pkg::cp0_n_status, "status", 32'h0040_0000);
        expect_reg(cp0_pkg::cp0_n_ebase, "ebase", 32'h8000_0000);
        expect_reg(cp0_pkg::cp0_n_prid, "prid", 32'h0001_8003);
        expect_reg(cp0_pkg::cp0_n_random, "random", 32'd31);
    endtask

    task automatic write_masks();
        cp0_write(cp0_pkg::cp0_n_status, 32'hffff_ffff);
        expect_reg(cp0_pkg::cp0_n_status, "status", 32'h1040_ff13);
        cp0_write(cp0_pkg::cp0_n_cause, 32'hffff_ffff);
        expect_reg(cp0_pkg::cp0_n_cause, "cause", 32'h0080_0300);
        cp0_write(cp0_pkg::cp0_n_entryhi, 32'hffff_ffff);
        expect_reg(cp0_pkg::cp0_n_entryhi, "entryhi", 32'hffff_e0ff);
        cp0_write(cp0_pkg::cp0_n_ebase, 32'hffff_ffff);
        expect_reg(cp0_pkg::cp0_n_ebase, "ebase", 32'hbfff_f000);
        cp0_write(cp0_pkg::cp0_n_config0, 32'hffff_ffff);
        expect_reg(cp0_pkg::cp0_n_config0, "config0", 32'h8000_0087);
        check_bit("kseg0_cached_o", 1'b0, kseg0_cached_o);
        cp0_write(cp0_pkg::cp0_n_epc, 32'hffff_ffff);
        expect_reg(cp0_pkg::cp0_n_epc, "epc", 32'hffff_ffff);
        cp0_write(cp0_pkg::cp0_n_taglo0, 32'hffff_ffff);
        expect_reg(cp0_pkg::cp0_n_taglo0, "taglo0", 32'hffff_ffff);
        cp0_write(cp0_pkg::cp0_n_wired, 32'd5);
        expect_reg(cp0_pkg::cp0_n_wired, "wired", 32'd5);
        expect_reg(cp0_pkg::cp0_n_random, "random", 32'd31);
        // back to boot state for the tests that follow
        cp0_write(cp0_pkg::cp0_n_status, 32'h0040_0000);
        cp0_write(cp0_pkg::cp0_n_cause, 32'd0);
        cp0_write(cp0_pkg::cp0_n_config0, 32'd3);
        check_bit("kseg0_cached_o", 1'b1, kseg0_cached_o);
    endtask

    task automatic exception_recording();
        logic [31:0] addr;
        addr = 32'h1234_5678;
        pulse_exception(exc_pkg::exc_tlbl, 1'b1, 32'h8000_1234, addr);
        check_word("epc_o", 32'h8000_1234, epc_o);
        expect_reg(cp0_pkg::cp0_n_badvaddr, "badvaddr", addr);
        expect_reg(cp0_pkg::cp0_n_epc, "epc", 32'h8000_1234);
        // BD in bit 31, ExcCode 2 in bits 6..2
        expect_reg(cp0_pkg::cp0_n_cause, "cause", 32'h8000_0008);
        expect_reg(cp0_pkg::cp0_n_context, "context", {9'd0, addr[31:13], 4'd0});
        expect_reg(cp0_pkg::cp0_n_entryhi, "entryhi", {addr[31:13], 13'h00ff});
        expect_reg(cp0_pkg::cp0_n_status, "status", 32'h0040_0002);
        // nested AdEL keeps EPC and BD
        pulse_exception(exc_pkg::exc_adel, 1'b0, 32'h8000_5678, 32'h0000_0123);
        check_word("epc_o", 32'h8000_1234, epc_o);
        expect_reg(cp0_pkg::cp0_n_badvaddr, "badvaddr", 32'h0000_0123);
        expect_reg(cp0_pkg::cp0_n_cause, "cause", 32'h8000_0010);
        pulse_exception(exc_pkg::exc_eret, 1'b0, 32'd0, 32'd0);
        expect_reg(cp0_pkg::cp0_n_status, "status", 32'h0040_0000);
        check_word("epc_o", 32'h8000_1234, epc_o);
    endtask

    task automatic vector_outputs();
        cp0_write(cp0_pkg::cp0_n_status, 32'd0);
        cp0_write(cp0_pkg::cp0_n_ebase, 32'h8000_1000);
        cp0_write(cp0_pkg::cp0_n_cause, 32'h0080_0000);
        check_word("exc_handler_o", 32'h8000_1180, exc_handler_o);
        check_word("int_handler_o", 32'h8000_1200, int_handler_o);
        check_word("tlb_refill_handler_o", 32'h8000_1000, tlb_refill_handler_o);
        cp0_write(cp0_pkg::cp0_n_status, 32'h0000_0002);
        check_word("exc_handler_o", 32'h8000_1180, exc_handler_o);
        check_word("int_handler_o", 32'h8000_1200, int_handler_o);
        check_word("tlb_refill_handler_o", 32'h8000_1180, tlb_refill_handler_o);
        cp0_write(cp0_pkg::cp0_n_cause, 32'd0);
        check_word("int_handler_o", 32'h8000_1180, int_handler_o);
        cp0_write(cp0_pkg::cp0_n_status, 32'd0);
        check_word("tlb_refill_handler_o", 32'h8000_1000, tlb_refill_handler_o);
    endtask

    task automatic interrupt_flags();
        logic [31:0] count_now;
        logic [31:0] rd;
        int waited;
        // IE plus IM2, which belongs to hw line 0
        cp0_write(cp0_pkg::cp0_n_status, 32'h0000_0401);
        drive_hw_lines(5'b00001);
        check_bit("interrupt_pending_o", 1'b1, interrupt_pending_o);
        drive_hw_lines(5'b00010);
        check_bit("interrupt_pending_o", 1'b0, interrupt_pending_o);
        drive_hw_lines(5'b00000);
        // IE plus IM7 for the timer
        cp0_write(cp0_pkg::cp0_n_status, 32'h0000_8001);
        cp0_read(cp0_pkg::cp0_n_count, count_now);
        cp0_write(cp0_pkg::cp0_n_compare, count_now + 32'd4);
        waited = 0;
        while (!interrupt_pending_o && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!interrupt_pending_o) begin
            $display("timer match did not raise interrupt_pending_o within 20 cycles");
            errors++;
        end
        cp0_read(cp0_pkg::cp0_n_cause, rd);
        check_bit("cause.ip7", 1'b1, rd[15]);
        cp0_write(cp0_pkg::cp0_n_compare, 32'd0);
        cp0_read(cp0_pkg::cp0_n_cause, rd);
        check_bit("cause.ip7", 1'b0, rd[15]);
        check_bit("interrupt_pending_o", 1'b0, interrupt_pending_o);
    endtask

    initial begin
        reset          = 1'b1;
        req_i          = 1'b0;
        write_i        = 1'b0;
        reg_num_i      = cp0_pkg::cp0_n_index;
        wdata_i        = 32'd0;
        exc_valid_i    = 1'b0;
        exc_code_i     = exc_pkg::exc_int;
        exc_bd_i       = 1'b0;
        exc_epc_i      = 32'd0;
        exc_badvaddr_i = 32'd0;
        hw_int_i       = 5'd0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        err_mark = errors;
        reset_state();
        report_test("reset state", err_mark);
        err_mark = errors;
        write_masks();
        report_test("write masks", err_mark);
        err_mark = errors;
        exception_recording();
        report_test("exception recording", err_mark);
        err_mark = errors;
        vector_outputs();
        report_test("vectors", err_mark);
        err_mark = errors;
        interrupt_flags();
        report_test("interrupts", err_mark);

        $display("tests run: %0d, tests failed: %0d, checks failed: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cp0_unit.f */
source/cp0_pkg.sv
source/exc_pkg.sv
source/cp0_ifaces.sv
source/cp0_access_ctrl.sv
source/cp0_timer.sv
source/cp0_regs.sv
source/cp0_unit.sv
tests/cp0_unit_chk.sv
tests/cp0_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cp0_unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cp0_unit_tb \
    -f cp0_unit.f

out=$(./obj_dir/Vcp0_unit_tb)
echo "$out"

echo "$out" | grep -q "^Simulation passed$"
